// ==== Makefile ====
.PHONY: all build lint clean

all: build
	-./obj_dir/VProcessorSC_tb > sim.log 2>&1
	@cat sim.log
	@grep -q "Test completed successfully" sim.log

build:
	verilator --binary --timing --timescale 1ns/100ps --top-module ProcessorSC_tb -f all.f

lint:
	verilator --lint-only -Wall +incdir+logic --top-module ProcessorSC \
		logic/CorePkg.sv logic/IsaPkg.sv logic/CoreIfc.sv logic/FetchUnit.sv \
		logic/DatapathController.sv logic/RegisterFile.sv logic/ExecuteUnit.sv \
		logic/MemoryAccess.sv logic/ProcessorSC.sv

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
+incdir+logic
logic/CorePkg.sv
logic/IsaPkg.sv
logic/CoreIfc.sv
logic/FetchUnit.sv
logic/DatapathController.sv
logic/RegisterFile.sv
logic/ExecuteUnit.sv
logic/MemoryAccess.sv
logic/ProcessorSC.sv
verification/ProcessorSC_tb.sv

// ==== logic/CoreIfc.sv ====
// Decoded control and operands, one instruction per cycle
interface DecodeBus;
    IsaPkg::AluOp       aluOp;
    IsaPkg::OperandASel operandASel;
    IsaPkg::OperandBSel operandBSel;
    logic               regWrEnable;  // Register write-back
    IsaPkg::WbSel       wbSel;
    logic               memWrEnable;  // Data memory store
    IsaPkg::PcSel       pcSel;        // Branch already resolved
    logic               unsignedCmp;  // BLTU/BGEU compare
    CorePkg::Word       imm;          // Sign-extended immediate
    CorePkg::RegIdx     rs1;
    CorePkg::RegIdx     rs2;
    CorePkg::RegIdx     rd;

    modport ctrl (output aluOp, operandASel, operandBSel, regWrEnable, wbSel,
                  memWrEnable, pcSel, unsignedCmp, imm, rs1, rs2, rd);
    modport exec (input aluOp, operandASel, operandBSel, unsignedCmp, imm,
                  rs1, rs2, rd, regWrEnable);
    modport fetch (input pcSel, imm);
    modport mem (input memWrEnable, wbSel);
endinterface

// Register data, ALU result and compare flags
interface ExecBus;
    CorePkg::Word rs1Data;
    CorePkg::Word rs2Data;   // Also store data
    CorePkg::Word aluResult; // Also data memory address
    logic         isEq;      // rs1 == rs2
    logic         isLt;      // rs1 < rs2, signedness per unsignedCmp

    modport exec (output rs1Data, rs2Data, aluResult, isEq, isLt);
    modport fetch (input rs1Data);
    modport mem (input rs2Data, aluResult);
    modport ctrl (input isEq, isLt);
endinterface

// ==== logic/CorePkg.sv ====
`include "core_consts.svh"

package CorePkg;

    // Data word, also the width of every ALU operand
    typedef logic [`CORE_DATA_WIDTH-1:0] Word;

    // Byte address for PC and data memory
    typedef logic [`CORE_ADDR_WIDTH-1:0] Addr;

    // Register number x0..x31
    typedef logic [`CORE_REG_IDX_WIDTH-1:0] RegIdx;

    // Raw instruction as fetched
    typedef logic [`CORE_DATA_WIDTH-1:0] Inst;

endpackage

// ==== logic/DatapathController.sv ====
module DatapathController (
    input  logic         i_arstN,   // Only to mask writes in reset
    input  CorePkg::Inst i_Inst,
    DecodeBus.ctrl       o_Dec,
    ExecBus.ctrl         i_Exec);   // Compare flags for branches

    IsaPkg::Opcode      opcode;
    logic [2:0]         funct3;
    logic               funct7b30;  // SUB and SRA select
    CorePkg::Word       immI, immS, immB, immU, immJ;
    IsaPkg::AluOp       aluOp;
    IsaPkg::OperandASel opASel;
    IsaPkg::OperandBSel opBSel;
    IsaPkg::WbSel       wbSel;
    IsaPkg::PcSel       basePcSel;  // Jumps only
    CorePkg::Word       imm;
    logic               regWr, memWr, isBranch, unsignedCmp, branchTaken;

    // ALU operation of OP / OP_IMM
    function automatic IsaPkg::AluOp aluOpFor(input logic [2:0] f3, input logic b30,
                                              input logic isReg);
        case (IsaPkg::AluFunct3'(f3))
            IsaPkg::F3_ADD_SUB: return (isReg && b30) ? IsaPkg::ALU_SUB : IsaPkg::ALU_ADD;
            IsaPkg::F3_SLL:     return IsaPkg::ALU_SLL;
            IsaPkg::F3_SLT:     return IsaPkg::ALU_SLT;
            IsaPkg::F3_SLTU:    return IsaPkg::ALU_SLTU;
            IsaPkg::F3_XOR:     return IsaPkg::ALU_XOR;
            IsaPkg::F3_SRL_SRA: return b30 ? IsaPkg::ALU_SRA : IsaPkg::ALU_SRL;
            IsaPkg::F3_OR:      return IsaPkg::ALU_OR;
            default:            return IsaPkg::ALU_AND;
        endcase
    endfunction

    assign opcode    = IsaPkg::Opcode'(i_Inst[6:0]);
    assign funct3    = i_Inst[14:12];
    assign funct7b30 = i_Inst[30];

    // Immediate formats, all sign-extended from bit 31
    assign immI = {{20{i_Inst[31]}}, i_Inst[31:20]};
    assign immS = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
    assign immB = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7], i_Inst[30:25], i_Inst[11:8], 1'b0};
    assign immU = {i_Inst[31:12], 12'b0};
    assign immJ = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12], i_Inst[20], i_Inst[30:21], 1'b0};

    // Main decode; unknown opcodes fall through as no-op
    always_comb begin
        aluOp = IsaPkg::ALU_ADD;
        opASel = IsaPkg::OPA_RS1;
        opBSel = IsaPkg::OPB_IMM;
        wbSel = IsaPkg::WB_ALU;
        basePcSel = IsaPkg::PCS_PLUS4;
        imm = immI;
        regWr = 1'b0;
        memWr = 1'b0;
        isBranch = 1'b0;
        unsignedCmp = 1'b0;
        case (opcode)
            IsaPkg::OPC_OP: begin
                opBSel = IsaPkg::OPB_RS2;
                aluOp = aluOpFor(funct3, funct7b30, 1'b1);
                regWr = 1'b1;
            end
            IsaPkg::OPC_OP_IMM: begin
                aluOp = aluOpFor(funct3, funct7b30, 1'b0);  // imm[10] picks SRAI
                regWr = 1'b1;
            end
            IsaPkg::OPC_LUI: begin
                opASel = IsaPkg::OPA_ZERO;
                aluOp = IsaPkg::ALU_PASS_B;
                imm = immU;
                regWr = 1'b1;
            end
            IsaPkg::OPC_AUIPC: begin
                opASel = IsaPkg::OPA_PC;
                imm = immU;
                regWr = 1'b1;
            end
            IsaPkg::OPC_LOAD: begin
                regWr = (funct3 == 3'b010);  // LW only
                wbSel = IsaPkg::WB_MEM;
            end
            IsaPkg::OPC_STORE: begin
                imm = immS;
                memWr = (funct3 == 3'b010);  // SW only
            end
            IsaPkg::OPC_BRANCH: begin
                imm = immB;
                isBranch = 1'b1;
                unsignedCmp = funct3[1];
            end
            IsaPkg::OPC_JAL, IsaPkg::OPC_JALR: begin
                opASel = IsaPkg::OPA_PC;  // ALU sees PC+4 too
                opBSel = IsaPkg::OPB_FOUR;
                wbSel = IsaPkg::WB_PC_PLUS4;
                regWr = 1'b1;
                imm = (opcode == IsaPkg::OPC_JAL) ? immJ : immI;
                basePcSel = (opcode == IsaPkg::OPC_JAL) ? IsaPkg::PCS_PC_OFFSET
                                                        : IsaPkg::PCS_RS1_OFFSET;
            end
            default: ;
        endcase
    end

    // Branch resolution kept apart from decode
    always_comb begin
        case (IsaPkg::BranchCond'(funct3))
            IsaPkg::BR_BEQ:                  branchTaken = i_Exec.isEq;
            IsaPkg::BR_BNE:                  branchTaken = !i_Exec.isEq;
            IsaPkg::BR_BLT, IsaPkg::BR_BLTU: branchTaken = i_Exec.isLt;
            IsaPkg::BR_BGE, IsaPkg::BR_BGEU: branchTaken = !i_Exec.isLt;
            default:                         branchTaken = 1'b0;  // Reserved funct3
        endcase
    end

    assign o_Dec.pcSel = (isBranch && branchTaken) ? IsaPkg::PCS_PC_OFFSET : basePcSel;
    assign o_Dec.aluOp = aluOp;
    assign o_Dec.operandASel = opASel;
    assign o_Dec.operandBSel = opBSel;
    assign o_Dec.wbSel = wbSel;
    assign o_Dec.unsignedCmp = unsignedCmp;
    assign o_Dec.imm = imm;
    assign o_Dec.regWrEnable = regWr && i_arstN;  // No writes in reset
    assign o_Dec.memWrEnable = memWr && i_arstN;
    assign o_Dec.rs1 = i_Inst[19:15];
    assign o_Dec.rs2 = i_Inst[24:20];
    assign o_Dec.rd  = i_Inst[11:7];

endmodule

// ==== logic/ExecuteUnit.sv ====
module ExecuteUnit (
    input  logic         i_Clock,
    input  logic         i_arstN,
    DecodeBus.exec       i_Dec,
    ExecBus.exec         o_Exec,
    input  CorePkg::Addr i_Pc,
    input  CorePkg::Word i_WbData);  // From MemoryAccess

    CorePkg::Word rs1Data, rs2Data;
    CorePkg::Word operandA, operandB;
    CorePkg::Word aluResult;
    logic [4:0]   shamt;  // Low bits of B only

    RegisterFile
    regFile (
        .i_Clock    (i_Clock),
        .i_arstN    (i_arstN),
        .i_WrIdx    (i_Dec.rd),
        .i_RdIdxA   (i_Dec.rs1),
        .i_RdIdxB   (i_Dec.rs2),
        .i_WrData   (i_WbData),
        .i_WrEnable (i_Dec.regWrEnable),
        .o_RdDataA  (rs1Data),
        .o_RdDataB  (rs2Data));

    // Operand A
    always_comb begin
        case (i_Dec.operandASel)
            IsaPkg::OPA_RS1: operandA = rs1Data;
            IsaPkg::OPA_PC:  operandA = CorePkg::Word'(i_Pc);  // AUIPC, jumps
            default:         operandA = '0;
        endcase
    end

    // Operand B
    always_comb begin
        case (i_Dec.operandBSel)
            IsaPkg::OPB_RS2:  operandB = rs2Data;
            IsaPkg::OPB_IMM:  operandB = i_Dec.imm;
            IsaPkg::OPB_FOUR: operandB = CorePkg::Word'(4);
            default:          operandB = '0;
        endcase
    end

    assign shamt = operandB[4:0];

    // ALU
    always_comb begin
        case (i_Dec.aluOp)
            IsaPkg::ALU_SUB:    aluResult = operandA - operandB;
            IsaPkg::ALU_AND:    aluResult = operandA & operandB;
            IsaPkg::ALU_OR:     aluResult = operandA | operandB;
            IsaPkg::ALU_XOR:    aluResult = operandA ^ operandB;
            IsaPkg::ALU_SLL:    aluResult = operandA << shamt;
            IsaPkg::ALU_SRL:    aluResult = operandA >> shamt;
            IsaPkg::ALU_SRA:    aluResult = CorePkg::Word'($signed(operandA) >>> shamt);
            IsaPkg::ALU_SLT:    aluResult = CorePkg::Word'($signed(operandA) < $signed(operandB));
            IsaPkg::ALU_SLTU:   aluResult = CorePkg::Word'(operandA < operandB);
            IsaPkg::ALU_PASS_B: aluResult = operandB;  // LUI
            default:            aluResult = operandA + operandB;
        endcase
    end

    // Branch comparer, raw register values
    assign o_Exec.isEq = (rs1Data == rs2Data);
    assign o_Exec.isLt = i_Dec.unsignedCmp ? (rs1Data < rs2Data)
                                           : ($signed(rs1Data) < $signed(rs2Data));

    assign o_Exec.rs1Data   = rs1Data;
    assign o_Exec.rs2Data   = rs2Data;
    assign o_Exec.aluResult = aluResult;

endmodule

// ==== logic/FetchUnit.sv ====
`include "core_consts.svh"

module FetchUnit (
    input  logic         i_Clock,
    input  logic         i_arstN,
    DecodeBus.fetch      i_Dec,     // pcSel and branch/jump offset
    ExecBus.fetch        i_Exec,    // rs1 for JALR
    output CorePkg::Addr o_Pc,      // Also program memory address
    output CorePkg::Addr o_PcPlus4);

    CorePkg::Addr pc;          // Current PC
    CorePkg::Addr pcNext;      // Loaded at next edge
    CorePkg::Addr pcPlus4;     // Sequential
    CorePkg::Addr pcOffset;    // Branch and JAL target
    CorePkg::Addr rs1Offset;   // JALR target before bit 0 clear
    CorePkg::Addr offset;

    assign offset    = CorePkg::Addr'(i_Dec.imm);
    assign pcPlus4   = pc + CorePkg::Addr'(4);
    assign pcOffset  = pc + offset;
    assign rs1Offset = CorePkg::Addr'(i_Exec.rs1Data) + offset;

    // Next PC select
    always_comb begin
        unique case (i_Dec.pcSel)
            IsaPkg::PCS_PC_OFFSET:  pcNext = pcOffset;
            IsaPkg::PCS_RS1_OFFSET: pcNext = {rs1Offset[$bits(CorePkg::Addr)-1:1], 1'b0};
            default:                pcNext = pcPlus4;  // PCS_PLUS4 and no-ops
        endcase
    end

    // PC register, one update per instruction
    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            pc <= `CORE_RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign o_Pc      = pc;
    assign o_PcPlus4 = pcPlus4;

    // Targets from decoder offsets and register data must keep PC on a word
    pcAligned: assert property (
        @(posedge i_Clock) disable iff (!i_arstN)
        pc[1:0] == 2'b00)
        else $error("PC 0x%08h not word aligned", pc);

endmodule

// ==== logic/IsaPkg.sv ====
package IsaPkg;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // Register ALU ops
        OPC_OP_IMM = 7'b0010011,  // Immediate ALU ops
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } Opcode;

    // funct3 of OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000, F3_SLL = 3'b001, F3_SLT = 3'b010, F3_SLTU = 3'b011,
        F3_XOR     = 3'b100, F3_SRL_SRA = 3'b101, F3_OR = 3'b110, F3_AND = 3'b111
    } AluFunct3;

    // funct3 of BRANCH; bit 1 marks the unsigned forms
    typedef enum logic [2:0] {
        BR_BEQ = 3'b000, BR_BNE = 3'b001, BR_BLT = 3'b100,
        BR_BGE = 3'b101, BR_BLTU = 3'b110, BR_BGEU = 3'b111
    } BranchCond;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } AluOp;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} OperandASel;
    typedef enum logic [1:0] {OPB_RS2, OPB_IMM, OPB_FOUR} OperandBSel;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC_PLUS4} WbSel;
    typedef enum logic [1:0] {PCS_PLUS4, PCS_PC_OFFSET, PCS_RS1_OFFSET} PcSel;

endpackage

// ==== logic/MemoryAccess.sv ====
module MemoryAccess (
    DecodeBus.mem        i_Dec,
    ExecBus.mem          i_Exec,
    input  CorePkg::Addr i_PcPlus4,      // Link value of JAL/JALR
    input  CorePkg::Word i_MemRdData,    // Combinational read data
    output CorePkg::Addr o_MemAddr,
    output logic         o_MemWrEnable,
    output CorePkg::Word o_MemWrData,
    output CorePkg::Word o_WbData);      // To register file

    // Data memory port
    assign o_MemAddr     = CorePkg::Addr'(i_Exec.aluResult);  // rs1 + offset
    assign o_MemWrEnable = i_Dec.memWrEnable;
    assign o_MemWrData   = i_Exec.rs2Data;

    // Write-back select
    always_comb begin
        case (i_Dec.wbSel)
            IsaPkg::WB_MEM:      o_WbData = i_MemRdData;
            IsaPkg::WB_PC_PLUS4: o_WbData = CorePkg::Word'(i_PcPlus4);
            default:             o_WbData = i_Exec.aluResult;
        endcase
    end

    // SW address comes from register data plus S immediate
    always_comb begin
        if (o_MemWrEnable) begin
            storeAligned: assert (o_MemAddr[1:0] == 2'b00)
                else $error("Store to unaligned address 0x%08h", o_MemAddr);
        end
    end

endmodule

// ==== logic/ProcessorSC.sv ====
module ProcessorSC (
    input  logic         i_Clock,
    input  logic         i_arstN,

    output CorePkg::Addr o_MemAddr,      // Data memory address
    output logic         o_MemWrEnable,  // Store strobe, sampled on edge
    output CorePkg::Word o_MemWrData,
    input  CorePkg::Word i_MemRdData,

    output CorePkg::Addr o_PgmAddr,      // Current PC
    input  CorePkg::Inst i_PgmInst);

    DecodeBus decBus ();
    ExecBus   exeBus ();

    CorePkg::Addr pcPlus4;
    CorePkg::Word wbData;  // Register write-back value

    FetchUnit
    fetch (
        .i_Clock   (i_Clock),
        .i_arstN   (i_arstN),
        .i_Dec     (decBus),
        .i_Exec    (exeBus),
        .o_Pc      (o_PgmAddr),
        .o_PcPlus4 (pcPlus4));

    DatapathController
    dpCtrl (
        .i_arstN (i_arstN),
        .i_Inst  (i_PgmInst),
        .o_Dec   (decBus),
        .i_Exec  (exeBus));

    ExecuteUnit
    execute (
        .i_Clock  (i_Clock),
        .i_arstN  (i_arstN),
        .i_Dec    (decBus),
        .o_Exec   (exeBus),
        .i_Pc     (o_PgmAddr),
        .i_WbData (wbData));

    MemoryAccess
    memAccess (
        .i_Dec         (decBus),
        .i_Exec        (exeBus),
        .i_PcPlus4     (pcPlus4),
        .i_MemRdData   (i_MemRdData),
        .o_MemAddr     (o_MemAddr),
        .o_MemWrEnable (o_MemWrEnable),
        .o_MemWrData   (o_MemWrData),
        .o_WbData      (wbData));

endmodule

// ==== logic/RegisterFile.sv ====
`include "core_consts.svh"

module RegisterFile (
    input  logic           i_Clock,
    input  logic           i_arstN,
    input  CorePkg::RegIdx i_WrIdx,
    input  CorePkg::RegIdx i_RdIdxA,
    input  CorePkg::RegIdx i_RdIdxB,
    input  CorePkg::Word   i_WrData,
    input  logic           i_WrEnable,
    output CorePkg::Word   o_RdDataA,
    output CorePkg::Word   o_RdDataB);

    CorePkg::Word regs [0:`CORE_REG_COUNT-1];  // x0 entry cleared in reset, never written

    // Write at the edge; index 0 dropped
    always_ff @(posedge i_Clock or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_WrEnable && (i_WrIdx != '0)) begin
            regs[i_WrIdx] <= i_WrData;
        end
    end

    // Combinational reads
    assign o_RdDataA = regs[i_RdIdxA];
    assign o_RdDataB = regs[i_RdIdxB];

    // x0 stays zero even right after a write aimed at it
    x0ReadsZero: assert property (
        @(posedge i_Clock) disable iff (!i_arstN)
        ((i_RdIdxA == '0) |-> (o_RdDataA == '0)) and
        ((i_RdIdxB == '0) |-> (o_RdDataB == '0)))
        else $error("x0 read returned non-zero");

endmodule

// ==== logic/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath word width
`define CORE_DATA_WIDTH 32

// Byte address width, shared by program and data memory
`define CORE_ADDR_WIDTH 32

// Register number width
`define CORE_REG_IDX_WIDTH 5

// Architectural registers, x0 included
`define CORE_REG_COUNT 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// ==== verification/ProcessorSC_tb.sv ====
module ProcessorSC_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // RV32I major opcodes, from the ISA manual
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    logic         clock;
    logic         arstN;
    CorePkg::Addr memAddr;
    logic         memWrEnable;
    CorePkg::Word memWrData;
    CorePkg::Word memRdData;
    CorePkg::Addr pgmAddr;
    CorePkg::Inst pgmInst;

    CorePkg::Inst pgm [0:255];      // Program memory, word indexed
    CorePkg::Word dmem [0:255];     // Data memory seen by the DUT
    CorePkg::Word refMem [0:255];   // Shadow data memory
    CorePkg::Word refRegs [0:31];   // Shadow register file
    CorePkg::Addr refPc;
    logic         refStoreEn;       // Expected store this cycle
    CorePkg::Addr refStoreAddr;
    CorePkg::Word refStoreData;

    integer       seed;
    logic [7:0]   pgmLen;           // Instructions emitted so far
    logic [11:0]  storeOffset;      // Next result slot
    CorePkg::Addr endAddr;          // Final self-loop
    logic         checking;
    logic         reachedEnd;       // Checker saw the DUT at the final loop
    int           cycles;

    ProcessorSC
    DUT (
        .i_Clock       (clock),
        .i_arstN       (arstN),
        .o_MemAddr     (memAddr),
        .o_MemWrEnable (memWrEnable),
        .o_MemWrData   (memWrData),
        .i_MemRdData   (memRdData),
        .o_PgmAddr     (pgmAddr),
        .i_PgmInst     (pgmInst));

    always #20 clock = ~clock;  // 40 ns period

    // Both memories answer in the same cycle
    assign pgmInst   = pgm[pgmAddr[9:2]];
    assign memRdData = dmem[memAddr[9:2]];

    always @(posedge clock) begin
        if (memWrEnable) begin
            dmem[memAddr[9:2]] <= memWrData;
        end
    end

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "Simulation stopped after first error");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            stopOnError($sformatf("MISMATCH at time %0t: %s is 0x%08h, expected 0x%08h",
                                  $time, what, actual, expected));
        end
    endtask

    // Instruction encoders
    function automatic CorePkg::Inst encR(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic CorePkg::Inst encI(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic CorePkg::Inst encS(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};  // SW only
    endfunction

    function automatic CorePkg::Inst encB(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic CorePkg::Inst encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // ALU result per funct3; alt selects SUB or SRA
    function automatic CorePkg::Word aluRef(input logic [2:0] f3, input logic alt,
                                            input CorePkg::Word a, input CorePkg::Word b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];  // Sign fill
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction on the shadow state
    function automatic void refStep(input CorePkg::Inst inst);
        logic [6:0]   opc;
        logic [2:0]   f3;
        logic [4:0]   rd;
        CorePkg::Word a, b, immI, immS, immB, immU, immJ, result, addr;
        CorePkg::Addr nextPc;
        logic         wr, taken;
        opc = inst[6:0];
        f3 = inst[14:12];
        rd = inst[11:7];
        a = refRegs[inst[19:15]];
        b = refRegs[inst[24:20]];
        immI = {{20{inst[31]}}, inst[31:20]};
        immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        immU = {inst[31:12], 12'b0};
        immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        result = '0;
        wr = 1'b0;
        taken = 1'b0;
        nextPc = refPc + 32'd4;  // Also for unsupported opcodes
        refStoreEn = 1'b0;
        case (opc)
            opReg: begin
                wr = 1'b1;
                result = aluRef(f3, inst[30], a, b);
            end
            opImm: begin
                wr = 1'b1;
                result = aluRef(f3, (f3 == 3'b101) && inst[30], a, immI);  // No SUBI
            end
            opLui: begin
                wr = 1'b1;
                result = immU;
            end
            opAuipc: begin
                wr = 1'b1;
                result = refPc + immU;
            end
            opLoad: begin
                addr = a + immI;
                wr = (f3 == 3'b010);
                result = refMem[addr[9:2]];
            end
            opStore: begin
                addr = a + immS;
                refStoreEn = (f3 == 3'b010);
                refStoreAddr = addr;
                refStoreData = b;
                if (refStoreEn) begin
                    refMem[addr[9:2]] = b;
                end
            end
            opBranch: begin
                case (f3)
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = ($signed(a) < $signed(b));
                    3'b101: taken = ($signed(a) >= $signed(b));
                    3'b110: taken = (a < b);
                    3'b111: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    nextPc = refPc + immB;
                end
            end
            opJal: begin
                wr = 1'b1;
                result = refPc + 32'd4;
                nextPc = refPc + immJ;
            end
            opJalr: begin
                wr = 1'b1;
                result = refPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;  // Bit 0 cleared
            end
            default: ;
        endcase
        if (wr && (rd != 5'd0)) begin
            refRegs[rd] = result;
        end
        refPc = nextPc;
    endfunction

    task automatic appendInst(input CorePkg::Inst inst);
        pgm[pgmLen] = inst;
        pgmLen = pgmLen + 8'd1;
    endtask

    task automatic storeResult(input logic [4:0] rs);
        appendInst(encS(storeOffset, rs, 5'd0));  // Absolute address off x0
        storeOffset = storeOffset + 12'd4;
    endtask

    task automatic buildProgram();
        logic [2:0]   rF3 [0:9] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5, 3'd5, 3'd2, 3'd3};
        logic [6:0]   rF7 [0:9] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
                                    7'h00, 7'h00};
        logic [2:0]   iF3 [0:5] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        logic [2:0]   bF3 [0:5] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [4:0]   srcA [0:3] = '{5'd7, 5'd8, 5'd1, 5'd1};
        logic [4:0]   srcB [0:3] = '{5'd8, 5'd7, 5'd2, 5'd1};
        CorePkg::Word rnd;
        pgmLen = 8'd0;
        storeOffset = 12'h200;
        appendInst(encS(12'h3fc, 5'd0, 5'd0));  // Store already at PC 0, masked in reset
        appendInst(encI(12'h000, 5'd0, 3'b010, 5'd1, opLoad));  // Random operands
        appendInst(encI(12'h004, 5'd0, 3'b010, 5'd2, opLoad));
        appendInst(encI(12'h008, 5'd0, 3'b010, 5'd3, opLoad));
        appendInst(encI(12'hfff, 5'd0, 3'd0, 5'd7, opImm));  // x7 = -1
        appendInst(encI(12'h001, 5'd0, 3'd0, 5'd8, opImm));  // x8 = 1
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < 10; i++) begin
                appendInst(encR(rF7[i], srcB[p], srcA[p], rF3[i], 5'd4));
                storeResult(5'd4);
            end
        end
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            appendInst(encI(rnd[11:0], 5'd1, iF3[i], 5'd4, opImm));
            storeResult(5'd4);
        end
        rnd = $random(seed);
        appendInst(encI({7'h00, rnd[4:0]}, 5'd2, 3'b001, 5'd4, opImm));   // SLLI
        storeResult(5'd4);
        appendInst(encI({7'h00, rnd[9:5]}, 5'd2, 3'b101, 5'd4, opImm));   // SRLI
        storeResult(5'd4);
        appendInst(encI({7'h20, rnd[14:10]}, 5'd2, 3'b101, 5'd4, opImm)); // SRAI
        storeResult(5'd4);
        appendInst(encS(12'h300, 5'd4, 5'd0));  // SW then LW back
        appendInst(encI(12'h300, 5'd0, 3'b010, 5'd5, opLoad));
        appendInst(encI(rnd[31:20], 5'd5, 3'd0, 5'd6, opImm));
        storeResult(5'd6);
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 4; p++) begin
                appendInst(encB(13'd8, srcB[p], srcA[p], bF3[c]));
                appendInst(encI(12'h001, 5'd9, 3'd0, 5'd9, opImm));  // Skipped when taken
            end
        end
        storeResult(5'd9);
        appendInst(encJ(21'd8, 5'd10));  // JAL over one
        appendInst(encI(12'h005, 5'd0, 3'd0, 5'd11, opImm));
        storeResult(5'd10);
        storeResult(5'd11);
        appendInst({20'h00000, 5'd12, opAuipc});  // x12 = own PC
        appendInst(encI(12'd13, 5'd12, 3'd0, 5'd13, opJalr));  // Odd target
        appendInst(encI(12'h001, 5'd11, 3'd0, 5'd11, opImm));
        storeResult(5'd13);
        storeResult(5'd11);
        appendInst(encI(12'd99, 5'd0, 3'd0, 5'd0, opImm));  // x0 writes dropped
        appendInst(encJ(21'd4, 5'd0));
        storeResult(5'd0);
        rnd = $random(seed);
        appendInst({rnd[19:0], 5'd14, opLui});
        storeResult(5'd14);
        appendInst({rnd[31:12], 5'd15, opAuipc});
        storeResult(5'd15);
        endAddr = {22'b0, pgmLen, 2'b00};
        appendInst(encJ(21'd0, 5'd0));  // Self-loop ends the run
    endtask

    // Compare against the shadow model mid-cycle
    always @(negedge clock) begin
        if (checking) begin
            checkValue(pgmAddr, refPc, "PC");
            if (pgmAddr === endAddr) begin
                reachedEnd = 1'b1;  // PC already matched the shadow
            end
            refStep(pgm[refPc[9:2]]);
            checkValue({31'b0, memWrEnable}, {31'b0, refStoreEn}, "store strobe");
            if (refStoreEn) begin
                checkValue(memAddr, refStoreAddr, "store address");
                checkValue(memWrData, refStoreData, "store data");
            end
        end
    end

    initial begin
        clock = 1'b0;
        arstN = 1'b0;
        checking = 1'b0;
        reachedEnd = 1'b0;
        seed = 32'h653c;
        refPc = 32'h0;
        refStoreEn = 1'b0;
        refStoreAddr = '0;
        refStoreData = '0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $random(seed);
            refMem[i] = dmem[i];
        end
        buildProgram();
        repeat (10) begin
            @(negedge clock);
            checkValue(pgmAddr, 32'h0, "PC in reset");
            checkValue({31'b0, memWrEnable}, 32'h0, "store strobe in reset");
        end
        @(posedge clock);
        arstN <= 1'b1;
        checking = 1'b1;
        cycles = 0;
        while (!reachedEnd && (cycles < 2000)) begin
            @(negedge clock);
            cycles++;
        end
        if (!reachedEnd) begin
            stopOnError("Timeout: program never reached its final loop in 2000 cycles");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
